//--- design/spc_pkg.sv
// SPC stack shared widths, bus types and the stack command encoding
`default_nettype none

package spc_pkg;

   // 32 return addresses of 19 bits, as in the microcode sequencer
   localparam int SPC_DEPTH_LOG2 = 5;
   localparam int SPC_WIDTH      = 19;

   typedef logic [SPC_DEPTH_LOG2-1:0] spc_addr_t;
   typedef logic [SPC_WIDTH-1:0]      spc_word_t;

   typedef logic [1:0]  wb_adr_t;   // register select on the bus
   typedef logic [31:0] wb_data_t;  // stack words sit in the low bits

   typedef enum logic [1:0]
   {
      OP_PUSH   = 2'd0,
      OP_POP    = 2'd1,
      OP_PEEK   = 2'd2,
      OP_STATUS = 2'd3
   } spc_op_t;

endpackage

`default_nettype wire

//--- design/spc_dpram.sv
// SPC storage RAM with one write port and a registered read port that forwards new data
`default_nettype none
`timescale 1ns/1ps

module spc_dpram #(
   parameter int ADDR_W = spc_pkg::SPC_DEPTH_LOG2,
   parameter int DATA_W = spc_pkg::SPC_WIDTH
) (
   input  logic               clk_a,
   input  logic               reset,
   input  logic               wr_en,
   input  spc_pkg::spc_addr_t wr_addr,
   input  spc_pkg::spc_word_t wr_data,
   input  logic               rd_en,
   input  spc_pkg::spc_addr_t rd_addr,
   output spc_pkg::spc_word_t rd_data
);
   import spc_pkg::*;

   localparam int DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] mem [0:DEPTH-1];
   spc_word_t         rd_next;

   always_ff @(posedge clk_a)
   begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
   end

   // a read of the slot being written sees the new word
   always_comb
   begin
      if (wr_en && (wr_addr == rd_addr))
         rd_next = wr_data;
      else
         rd_next = mem[rd_addr];
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         rd_data <= '0;
      else if (rd_en)
         rd_data <= rd_next;
   end

   // the output register only moves on an enabled read
   a_rd_hold: assert property (
      @(posedge clk_a) disable iff (reset)
      (!$past(rd_en) && !$past(reset)) |-> $stable(rd_data)
   );

endmodule

`default_nettype wire

//--- design/spc_stack_ctrl.sv
// SPC stack controller keeping the wrapping pointer and sequencing commands onto the RAM
`default_nettype none
`timescale 1ns/1ps

module spc_stack_ctrl #(
   parameter int ADDR_W = spc_pkg::SPC_DEPTH_LOG2,
   parameter int DATA_W = spc_pkg::SPC_WIDTH
) (
   input  logic               clk_a,
   input  logic               reset,
   input  logic               cmd_valid,
   input  spc_pkg::spc_op_t   cmd_op,
   input  spc_pkg::spc_word_t cmd_data,
   output logic               rsp_valid,
   output spc_pkg::spc_word_t rsp_data,
   output logic               wr_en,
   output spc_pkg::spc_addr_t wr_addr,
   output spc_pkg::spc_word_t wr_data,
   output logic               rd_en,
   output spc_pkg::spc_addr_t rd_addr,
   input  spc_pkg::spc_word_t rd_data,
   output spc_pkg::spc_addr_t sp
);
   import spc_pkg::*;

   typedef enum logic
   {
      IDLE,
      READ_WAIT
   } state_t;

   state_t  state;
   spc_op_t rsp_op;                  // command that owns the current response

   assign wr_addr = sp + spc_addr_t'(1); // push goes one slot above the top
   assign rd_addr = sp;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         state     <= IDLE;
         rsp_op    <= OP_PUSH;
         rsp_valid <= 1'b0;
         wr_en     <= 1'b0;
         rd_en     <= 1'b0;
         sp        <= '0;
      end
      else
      begin
         rsp_valid <= 1'b0;
         wr_en     <= 1'b0;
         rd_en     <= 1'b0;
         if (wr_en)
            sp <= wr_addr;           // pointer steps on the write edge, wraps at 32
         case (state)
            IDLE:
            begin
               if (cmd_valid)
               begin
                  rsp_op <= cmd_op;
                  case (cmd_op)
                     OP_PUSH:
                     begin
                        wr_en     <= 1'b1;
                        rsp_valid <= 1'b1;
                     end
                     OP_POP, OP_PEEK:
                     begin
                        rd_en <= 1'b1;
                        state <= READ_WAIT;
                     end
                     default:
                        rsp_valid <= 1'b1;
                  endcase
               end
            end
            READ_WAIT:
            begin
               rsp_valid <= 1'b1;    // rd_data is valid from this edge
               state     <= IDLE;
               if (rsp_op == OP_POP)
                  sp <= sp - spc_addr_t'(1);
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (cmd_valid && (cmd_op == OP_PUSH))
         wr_data <= cmd_data;
   end

   always_comb
   begin
      case (rsp_op)
         OP_POP, OP_PEEK:
            rsp_data = rd_data;
         OP_STATUS:
            rsp_data = {{(DATA_W-ADDR_W){1'b0}}, sp};
         default:
            rsp_data = '0;
      endcase
   end

   // the bus slave must wait for the response before the next command
   a_no_cmd_in_read: assert property (
      @(posedge clk_a) disable iff (reset)
      (state == READ_WAIT) |-> !cmd_valid
   );

endmodule

`default_nettype wire

//--- design/spc_wb_slave.sv
// Wishbone classic slave turning bus cycles into stack commands and acknowledges
`default_nettype none
`timescale 1ns/1ps

module spc_wb_slave (
   input  logic               clk_a,
   input  logic               reset,
   input  logic               cyc,
   input  logic               stb,
   input  logic               we,
   input  spc_pkg::wb_adr_t   adr,
   input  spc_pkg::wb_data_t  dat_w,
   output spc_pkg::wb_data_t  dat_r,
   output logic               ack,
   output logic               cmd_valid,
   output spc_pkg::spc_op_t   cmd_op,
   output spc_pkg::spc_word_t cmd_data,
   input  logic               rsp_valid,
   input  spc_pkg::spc_word_t rsp_data
);
   import spc_pkg::*;

   localparam wb_adr_t ADR_STACK  = 2'd0;
   localparam wb_adr_t ADR_PEEK   = 2'd1;
   localparam wb_adr_t ADR_STATUS = 2'd2;

   typedef enum logic [1:0]
   {
      IDLE,
      WAIT_RSP,
      ACK
   } state_t;

   state_t  state;
   logic    stb_hold;                // master has not yet dropped stb after ack
   logic    start;
   logic    dec_mapped;
   spc_op_t dec_op;

   assign ack   = (state == ACK);
   assign start = (state == IDLE) && cyc && stb && !stb_hold;

   always_comb
   begin
      dec_mapped = 1'b1;
      dec_op     = OP_STATUS;
      case (adr)
         ADR_STACK:  dec_op = we ? OP_PUSH : OP_POP;
         ADR_PEEK:   dec_op = OP_PEEK;
         ADR_STATUS: dec_op = OP_STATUS;
         default:    dec_mapped = 1'b0;
      endcase
      if (we && (adr != ADR_STACK))
         dec_mapped = 1'b0;          // only the stack register takes writes
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         state     <= IDLE;
         cmd_valid <= 1'b0;
         stb_hold  <= 1'b0;
         dat_r     <= '0;
      end
      else
      begin
         cmd_valid <= 1'b0;
         if (state == ACK)
            stb_hold <= 1'b1;
         else if (!stb)
            stb_hold <= 1'b0;
         case (state)
            IDLE:
            begin
               if (start && dec_mapped)
               begin
                  cmd_valid <= 1'b1;
                  state     <= WAIT_RSP;
               end
               else if (start)
               begin
                  dat_r <= '0;       // unmapped access answers at once
                  state <= ACK;
               end
            end
            WAIT_RSP:
            begin
               if (rsp_valid)
               begin
                  dat_r <= wb_data_t'(rsp_data);
                  state <= ACK;
               end
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (start)
      begin
         cmd_op   <= dec_op;
         cmd_data <= dat_w[SPC_WIDTH-1:0];
      end
   end

   a_ack_pulse: assert property (
      @(posedge clk_a) disable iff (reset)
      ack |=> !ack
   );

endmodule

`default_nettype wire

//--- design/spc_stack_top.sv
// SPC return-address stack top level joining the bus slave, the controller and the RAM
`default_nettype none
`timescale 1ns/1ps

module spc_stack_top #(
   parameter int ADDR_W = spc_pkg::SPC_DEPTH_LOG2,
   parameter int DATA_W = spc_pkg::SPC_WIDTH
) (
   input  logic              clk_a,
   input  logic              reset,
   input  logic              cyc,
   input  logic              stb,
   input  logic              we,
   input  spc_pkg::wb_adr_t  adr,
   input  spc_pkg::wb_data_t dat_w,
   output spc_pkg::wb_data_t dat_r,
   output logic              ack
);
   import spc_pkg::*;

   logic      cmd_valid;
   spc_op_t   cmd_op;
   spc_word_t cmd_data;
   logic      rsp_valid;
   spc_word_t rsp_data;
   logic      wr_en;
   spc_addr_t wr_addr;
   spc_word_t wr_data;
   logic      rd_en;
   spc_addr_t rd_addr;
   spc_word_t rd_data;

   spc_wb_slave i_slave (
      .clk_a     (clk_a),
      .reset     (reset),
      .cyc       (cyc),
      .stb       (stb),
      .we        (we),
      .adr       (adr),
      .dat_w     (dat_w),
      .dat_r     (dat_r),
      .ack       (ack),
      .cmd_valid (cmd_valid),
      .cmd_op    (cmd_op),
      .cmd_data  (cmd_data),
      .rsp_valid (rsp_valid),
      .rsp_data  (rsp_data)
   );

   spc_stack_ctrl #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) i_ctrl (
      .clk_a     (clk_a),
      .reset     (reset),
      .cmd_valid (cmd_valid),
      .cmd_op    (cmd_op),
      .cmd_data  (cmd_data),
      .rsp_valid (rsp_valid),
      .rsp_data  (rsp_data),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .rd_en     (rd_en),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .sp        ()                  // the pointer reaches the bus through status reads
   );

   spc_dpram #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) i_ram (
      .clk_a   (clk_a),
      .reset   (reset),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

`default_nettype wire

//--- tb/tb_spc_stack.sv
// SPC stack testbench replaying the tests file as Wishbone cycles against a stack model
`default_nettype none
`timescale 1ns/1ps

module tb_spc_stack;
   import spc_pkg::*;

   localparam int ACK_TIMEOUT = 20;

   logic      clk_a;
   logic      reset;
   logic      cyc;
   logic      stb;
   logic      we;
   wb_adr_t   adr;
   wb_data_t  dat_w;
   wb_data_t  dat_r;
   logic      ack;

   spc_word_t model_mem [0:31];      // predicted RAM content
   spc_addr_t model_sp;
   int        errors;
   int        timeouts;
   int        checks;
   int        fd;
   int        code;
   logic [7:0]     op_c;
   wb_data_t       data;
   wb_data_t       expv;
   wb_data_t       rd_value;
   logic [8*128-1:0] skip_line;
   logic           done;

   spc_stack_top i_dut (
      .clk_a (clk_a),
      .reset (reset),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .dat_r (dat_r),
      .ack   (ack)
   );

   initial
   begin
      clk_a = 1'b0;
      forever
         #10 clk_a = ~clk_a;
   end

   // one classic cycle, held until ack is seen, then stb drops for a cycle
   task automatic bus_cycle(input logic wr, input wb_adr_t a, input wb_data_t d,
                            output wb_data_t q);
      int waited;
      waited = 0;
      q      = '0;
      @(posedge clk_a);
      cyc   <= 1'b1;
      stb   <= 1'b1;
      we    <= wr;
      adr   <= a;
      dat_w <= d;
      @(negedge clk_a);
      while (!ack && (waited < ACK_TIMEOUT))
      begin
         waited++;
         @(negedge clk_a);
      end
      if (ack)
         q = dat_r;
      else
      begin
         $display("%0t: no acknowledge from the stack", $time);
         timeouts++;
      end
      @(posedge clk_a);
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
   endtask

   task automatic compare_read(input logic [7:0] op, input wb_data_t got,
                               input wb_data_t model_val, input wb_data_t file_val);
      checks++;
      assert (got == model_val)
      else
      begin
         $display("MISMATCH at %0t: op %s read %h, model expects %h", $time, op, got, model_val);
         errors++;
      end
      assert (got == file_val)
      else
      begin
         $display("MISMATCH at %0t: op %s read %h, tests file expects %h", $time, op, got,
                  file_val);
         errors++;
      end
   endtask

   task automatic push_word(input wb_data_t d);
      wb_data_t push_rsp;
      model_sp = model_sp + 5'd1;    // slot above the old top, wraps at 32
      model_mem[model_sp] = d[SPC_WIDTH-1:0];
      bus_cycle(1'b1, 2'd0, d, push_rsp);
      checks++;
      assert (push_rsp == '0)        // a push answers with zero on the bus
      else
      begin
         $display("MISMATCH at %0t: push of %h read %h, expects 0", $time, d, push_rsp);
         errors++;
      end
   endtask

   initial
   begin
      cyc      = 1'b0;
      stb      = 1'b0;
      we       = 1'b0;
      adr      = '0;
      dat_w    = '0;
      reset    = 1'b1;
      errors   = 0;
      timeouts = 0;
      checks   = 0;
      model_sp = '0;
      done     = 1'b0;
      for (int i = 0; i < 32; i++)
         model_mem[i] = '0;
      repeat (5) @(posedge clk_a);
      reset <= 1'b0;

      fd = $fopen("tb/spc_tests.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the tests file tb/spc_tests.txt");
         errors++;
         done = 1'b1;
      end
      while (!done)
      begin
         code = $fscanf(fd, "%s", op_c);
         if (code != 1)
            done = 1'b1;
         else if (op_c == "#")
            code = $fgets(skip_line, fd);
         else if ($fscanf(fd, "%h %h", data, expv) != 2)
         begin
            $display("tests file line for op %s is missing its values", op_c);
            errors++;
            done = 1'b1;
         end
         else
         begin
            case (op_c)
               "P":
               begin
                  push_word(data);
                  assert (expv == wb_data_t'(data[SPC_WIDTH-1:0]))
                  else
                  begin
                     $display("tests file expects %h for a push of %h", expv, data);
                     errors++;
                  end
               end
               "F":
                  for (int i = 0; i < int'(expv); i++)
                     push_word(data + wb_data_t'(i));
               "O":
               begin
                  bus_cycle(1'b0, 2'd0, '0, rd_value);
                  compare_read(op_c, rd_value, wb_data_t'(model_mem[model_sp]), expv);
                  model_sp = model_sp - 5'd1;
               end
               "K":
               begin
                  bus_cycle(1'b0, 2'd1, '0, rd_value);
                  compare_read(op_c, rd_value, wb_data_t'(model_mem[model_sp]), expv);
               end
               "S":
               begin
                  bus_cycle(1'b0, 2'd2, '0, rd_value);
                  compare_read(op_c, rd_value, wb_data_t'(model_sp), expv);
               end
               "X":
               begin
                  bus_cycle(1'b0, 2'd3, '0, rd_value);
                  compare_read(op_c, rd_value, '0, expv);
               end
               "W":
                  bus_cycle(1'b1, 2'd3, data, rd_value);
               default:
               begin
                  $display("unknown operation %s in the tests file", op_c);
                  errors++;
               end
            endcase
         end
      end
      if (fd != 0)
         $fclose(fd);

      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if ((errors == 0) && (timeouts == 0) && (checks > 0))
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
design/spc_pkg.sv
design/spc_dpram.sv
design/spc_stack_ctrl.sv
design/spc_wb_slave.sv
design/spc_stack_top.sv
tb/tb_spc_stack.sv

//--- run.sh
#!/bin/sh
# compile and run the SPC stack testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
   --top-module tb_spc_stack -o sim_spc \
   && ./obj_dir/sim_spc > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -qx "TEST RESULT: PASS" sim.log && exit 0 || exit 1

//--- tb/spc_tests.txt
# op data expected, all hex. P push, O pop, K peek, S status, X read of adr 3, W write of adr 3
# F pushes a run of words counting up from data, and its third column is the number of words
S 0 0
K 0 0
P 1a2b 1a2b
S 0 1
P 3c4d 3c4d
S 0 2
P 7ffff 7ffff
S 0 3
O 0 7ffff
S 0 2
O 0 3c4d
S 0 1
O 0 1a2b
S 0 0
P 4567 4567
K 0 4567
K 0 4567
S 0 1
O 0 4567
P abcdef01 5ef01
O 0 5ef01
S 0 0
W 12345 0
X 0 0
S 0 0
F 100 21
S 0 1
K 0 120
O 0 120
O 0 11f
O 0 11e
S 0 1e
